// ==== include/conv_settings.svh ====
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// engine size
`define CONV_LANES              4
`define CONV_TAPS               8

// datapath widths
`define CONV_SAMPLE_W           16
`define CONV_COEF_W             16
`define CONV_ACC_W              36      // 32-bit product plus 4 guard bits
`define CONV_ADDR_W             12

// register map
`define CONV_REG_STATUS         12'h000
`define CONV_REG_DATA           12'h004
`define CONV_REG_COEF_BASE      12'h100
`define CONV_COEF_LANE_STRIDE   12'h020
`define CONV_COEF_TAP_STRIDE    12'h004
`define CONV_REG_RESULT_BASE    12'h200
`define CONV_RESULT_LANE_STRIDE 12'h008 // low word then high word

`endif

// ==== hw/conv_pkg.sv ====
`include "conv_settings.svh"

package conv_pkg;

    typedef logic signed [`CONV_SAMPLE_W-1:0]              sample_t;
    typedef logic signed [`CONV_COEF_W-1:0]                coef_t;
    typedef logic signed [`CONV_SAMPLE_W+`CONV_COEF_W-1:0] product_t;
    typedef logic signed [`CONV_ACC_W-1:0]                 acc_t;
    typedef logic [$clog2(`CONV_TAPS)-1:0]                 tap_idx_t;
    typedef logic [7:0]                                    block_cnt_t;
    typedef logic [`CONV_ADDR_W-1:0]                       apb_addr_t;
    typedef logic [31:0]                                   apb_data_t;

    // all taps of one filter, tap 0 in the low bits
    typedef coef_t [`CONV_TAPS-1:0] coef_bank_t;

    typedef struct packed {
        logic     valid;
        logic     first;
        logic     last;
        tap_idx_t tap;
        sample_t  sample;
    } lane_in_t;

    typedef struct packed {
        logic valid;    // only on the last tap of a block
        acc_t acc;
    } lane_out_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef enum logic {
        feed_idle,
        feed_block
    } feeder_state_e;

endpackage

// ==== hw/conv_apb_regs.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_apb_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  conv_pkg::apb_req_t   apb_req,
    output conv_pkg::apb_rsp_t   apb_rsp,
    input  conv_pkg::acc_t       results [`CONV_LANES],
    input  logic                 done,
    input  conv_pkg::block_cnt_t block_cnt,
    input  logic                 busy,
    output conv_pkg::coef_bank_t coef_banks [`CONV_LANES],
    output logic                 sample_wr,
    output conv_pkg::sample_t    sample_data,
    output logic                 done_clr
);

    localparam int LANE_W = $clog2(`CONV_LANES);

    localparam logic [`CONV_ADDR_W-1:0] COEF_END =
        `CONV_REG_COEF_BASE + `CONV_LANES * `CONV_COEF_LANE_STRIDE;
    localparam logic [`CONV_ADDR_W-1:0] RESULT_END =
        `CONV_REG_RESULT_BASE + `CONV_LANES * `CONV_RESULT_LANE_STRIDE;

    logic                    access;
    logic [`CONV_ADDR_W-1:0] coef_off;
    logic [`CONV_ADDR_W-1:0] res_off;
    logic                    status_hit;
    logic                    data_hit;
    logic                    coef_hit;
    logic                    res_hit;
    logic [LANE_W-1:0]       coef_lane;
    conv_pkg::tap_idx_t      coef_tap;
    logic [LANE_W-1:0]       res_lane;
    logic                    res_hi;

    // address decode
    always_comb begin
        access     = apb_req.psel && apb_req.penable;
        coef_off   = apb_req.paddr - `CONV_REG_COEF_BASE;
        res_off    = apb_req.paddr - `CONV_REG_RESULT_BASE;
        status_hit = apb_req.paddr == `CONV_REG_STATUS;
        data_hit   = apb_req.paddr == `CONV_REG_DATA;
        coef_hit   = apb_req.paddr >= `CONV_REG_COEF_BASE && apb_req.paddr < COEF_END &&
                     apb_req.paddr[1:0] == 2'b00;
        res_hit    = apb_req.paddr >= `CONV_REG_RESULT_BASE && apb_req.paddr < RESULT_END &&
                     apb_req.paddr[1:0] == 2'b00;
        coef_lane  = LANE_W'(coef_off / `CONV_COEF_LANE_STRIDE);
        coef_tap   = conv_pkg::tap_idx_t'((coef_off % `CONV_COEF_LANE_STRIDE) /
                                          `CONV_COEF_TAP_STRIDE);
        res_lane   = LANE_W'(res_off / `CONV_RESULT_LANE_STRIDE);
        res_hi     = res_off[2];    // high word sits at +4
    end

    // strobes towards feeder and collector
    assign sample_wr   = access && apb_req.pwrite && data_hit;
    assign sample_data = conv_pkg::sample_t'(apb_req.pwdata[`CONV_SAMPLE_W-1:0]);
    assign done_clr    = access && apb_req.pwrite && status_hit && apb_req.pwdata[0];

    // coefficient bank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int l = 0; l < `CONV_LANES; l++) begin
                coef_banks[l] <= '0;
            end
        end else if (access && apb_req.pwrite && coef_hit) begin
            coef_banks[coef_lane][coef_tap] <=
                conv_pkg::coef_t'(apb_req.pwdata[`CONV_COEF_W-1:0]);
        end
    end

    // read data and error response, valid in the access phase only
    always_comb begin
        apb_rsp        = '0;
        apb_rsp.pready = 1'b1;     // no wait states
        if (access) begin
            if (status_hit) begin
                if (!apb_req.pwrite) begin
                    apb_rsp.prdata[0]    = done;
                    apb_rsp.prdata[1]    = busy;
                    apb_rsp.prdata[15:8] = block_cnt;
                end
            end else if (data_hit) begin
                apb_rsp.pslverr = !apb_req.pwrite;  // DATA is write only
            end else if (coef_hit) begin
                if (!apb_req.pwrite) begin
                    // zero extended so a write reads back as written
                    apb_rsp.prdata[`CONV_COEF_W-1:0] = coef_banks[coef_lane][coef_tap];
                end
            end else if (res_hit) begin
                if (apb_req.pwrite) begin
                    apb_rsp.pslverr = 1'b1;
                end else if (res_hi) begin
                    // top accumulator bits, sign extended to a full word
                    apb_rsp.prdata = conv_pkg::apb_data_t'(results[res_lane] >>> 32);
                end else begin
                    apb_rsp.prdata = results[res_lane][31:0];
                end
            end else begin
                apb_rsp.pslverr = 1'b1;     // unmapped
            end
        end
    end

    // an access phase always follows a setup phase with psel held
    penable_after_setup: assert property (
        @(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel && $past(apb_req.psel)
    );

endmodule

// ==== hw/conv_feeder.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_feeder (
    input  logic               clk,
    input  logic               rst,
    input  logic               sample_wr,
    input  conv_pkg::sample_t  sample_data,
    output conv_pkg::lane_in_t lane_in,
    output logic               busy
);

    conv_pkg::feeder_state_e state;
    conv_pkg::tap_idx_t      tap_cnt;    // tap of the next sample
    logic                    block_end;
    logic                    valid_q;
    logic                    first_q;
    logic                    last_q;
    conv_pkg::tap_idx_t      tap_q;
    conv_pkg::sample_t       sample_q;

    assign block_end = tap_cnt == conv_pkg::tap_idx_t'(`CONV_TAPS - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= conv_pkg::feed_idle;
            tap_cnt <= '0;
            valid_q <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
            tap_q   <= '0;
        end else begin
            valid_q <= sample_wr;
            if (sample_wr) begin
                first_q <= tap_cnt == '0;
                last_q  <= block_end;
                tap_q   <= tap_cnt;
                tap_cnt <= block_end ? '0 : tap_cnt + 1'b1;
            end
            case (state)
                conv_pkg::feed_idle: begin
                    if (sample_wr && !block_end) state <= conv_pkg::feed_block;
                end
                conv_pkg::feed_block: begin
                    if (sample_wr && block_end) state <= conv_pkg::feed_idle;
                end
                default: state <= conv_pkg::feed_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample_wr) sample_q <= sample_data;
    end

    always_comb begin
        lane_in.valid  = valid_q;
        lane_in.first  = first_q;
        lane_in.last   = last_q;
        lane_in.tap    = tap_q;
        lane_in.sample = sample_q;
    end

    assign busy = state == conv_pkg::feed_block;

    // first tap only when the write arrived while idle
    tap_sequence: assert property (
        @(posedge clk) disable iff (rst)
        lane_in.valid |-> lane_in.first == !$past(busy)
    );

endmodule

// ==== hw/mac_lane.sv ====
`timescale 1ns/1ps

module mac_lane (
    input  logic                 clk,
    input  logic                 rst,
    input  conv_pkg::lane_in_t   lane_in,
    input  conv_pkg::coef_bank_t coef_bank,
    output conv_pkg::lane_out_t  lane_out
);

    conv_pkg::sample_t  sample_1p;
    conv_pkg::coef_t    coef_1p;
    logic               first_1p;
    logic               last_1p;

    conv_pkg::product_t product_2p;
    logic               first_2p;
    logic               last_2p;

    conv_pkg::acc_t     acc_3p;
    logic               last_3p;

    // datapath stages 1 and 2
    always_ff @(posedge clk) begin
        // idle cycles push a zero product through
        sample_1p  <= lane_in.valid ? lane_in.sample : '0;
        coef_1p    <= coef_bank[lane_in.tap];
        product_2p <= sample_1p * coef_1p;
    end

    // tags, accumulator and output register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            first_1p <= 1'b0;
            last_1p  <= 1'b0;
            first_2p <= 1'b0;
            last_2p  <= 1'b0;
            acc_3p   <= '0;
            last_3p  <= 1'b0;
            lane_out <= '0;
        end else begin
            first_1p <= lane_in.valid && lane_in.first;
            last_1p  <= lane_in.valid && lane_in.last;
            first_2p <= first_1p;
            last_2p  <= last_1p;
            last_3p  <= last_2p;

            // restart on tap 0 so blocks stay independent
            if (first_2p) begin
                acc_3p <= conv_pkg::acc_t'(product_2p);
            end else begin
                acc_3p <= acc_3p + conv_pkg::acc_t'(product_2p);
            end

            lane_out.valid <= last_3p;
            lane_out.acc   <= acc_3p;
        end
    end

    // a result always traces back to a last tap four stages earlier
    result_from_last_tap: assert property (
        @(posedge clk) disable iff (rst)
        lane_out.valid |-> $past(lane_in.valid && lane_in.last, 4)
    );

endmodule

// ==== hw/conv_collector.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_collector (
    input  logic                 clk,
    input  logic                 rst,
    input  conv_pkg::lane_out_t  lane_outs [`CONV_LANES],
    input  logic                 done_clr,
    output conv_pkg::acc_t       results [`CONV_LANES],
    output logic                 done,
    output conv_pkg::block_cnt_t block_cnt
);

    logic capture;

    // lanes run in lockstep so lane 0 speaks for all
    assign capture = lane_outs[0].valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int l = 0; l < `CONV_LANES; l++) begin
                results[l] <= '0;
            end
            block_cnt <= '0;
        end else if (capture) begin
            for (int l = 0; l < `CONV_LANES; l++) begin
                results[l] <= lane_outs[l].acc;
            end
            block_cnt <= block_cnt + 1'b1;  // wraps at 255
        end
    end

    // sticky done, a completion beats a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else if (capture) begin
            done <= 1'b1;
        end else if (done_clr) begin
            done <= 1'b0;
        end
    end

    // every lane sees the same feeder stream
    for (genvar l = 1; l < `CONV_LANES; l++) begin : g_lockstep
        lanes_in_lockstep: assert property (
            @(posedge clk) disable iff (rst)
            lane_outs[l].valid == lane_outs[0].valid
        );
    end

endmodule

// ==== hw/conv_top.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_top (
    input  logic               clk,
    input  logic               rst,
    input  conv_pkg::apb_req_t apb_req,
    output conv_pkg::apb_rsp_t apb_rsp
);

    conv_pkg::coef_bank_t coef_banks [`CONV_LANES];
    conv_pkg::acc_t       results [`CONV_LANES];
    conv_pkg::lane_out_t  lane_outs [`CONV_LANES];
    conv_pkg::lane_in_t   lane_in;          // broadcast to every lane
    conv_pkg::sample_t    sample_data;
    conv_pkg::block_cnt_t block_cnt;
    logic                 sample_wr;
    logic                 done_clr;
    logic                 done;
    logic                 busy;

    conv_apb_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .results     (results),
        .done        (done),
        .block_cnt   (block_cnt),
        .busy        (busy),
        .coef_banks  (coef_banks),
        .sample_wr   (sample_wr),
        .sample_data (sample_data),
        .done_clr    (done_clr)
    );

    conv_feeder u_feeder (
        .clk         (clk),
        .rst         (rst),
        .sample_wr   (sample_wr),
        .sample_data (sample_data),
        .lane_in     (lane_in),
        .busy        (busy)
    );

    // one filter per lane
    for (genvar i = 0; i < `CONV_LANES; i++) begin : g_lane
        mac_lane u_lane (
            .clk       (clk),
            .rst       (rst),
            .lane_in   (lane_in),
            .coef_bank (coef_banks[i]),
            .lane_out  (lane_outs[i])
        );
    end

    conv_collector u_collector (
        .clk       (clk),
        .rst       (rst),
        .lane_outs (lane_outs),
        .done_clr  (done_clr),
        .results   (results),
        .done      (done),
        .block_cnt (block_cnt)
    );

endmodule

// ==== tests/conv_tb.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_tb;

    localparam int DRIVE_DLY   = 1;    // ns after the rising edge
    localparam int N_TESTS     = 6;
    localparam int COEF_WRITES = `CONV_LANES * `CONV_TAPS;
    localparam int POLL_MAX    = 32;
    localparam int WATCHDOG_NS = N_TESTS * (COEF_WRITES + `CONV_TAPS + POLL_MAX) * 10 * 4;

    logic               clk;
    logic               rst;
    conv_pkg::apb_req_t apb_req;
    conv_pkg::apb_rsp_t apb_rsp;

    conv_pkg::coef_t    coefs [`CONV_LANES][`CONV_TAPS];
    conv_pkg::sample_t  samples [`CONV_TAPS];
    int                 blocks;
    int                 errs;
    int                 test_start_errs;
    int                 tests_passed;
    int                 tests_failed;

    // result words waiting for the checker
    conv_pkg::acc_t     exp_q [$];
    conv_pkg::acc_t     act_q [$];
    string              name_q [$];

    conv_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    task automatic check_acc(input string name, input conv_pkg::acc_t exp,
                             input conv_pkg::acc_t act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
            errs++;
        end
    endtask

    task automatic check_word(input string name, input conv_pkg::apb_data_t exp,
                              input conv_pkg::apb_data_t act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            errs++;
        end
    endtask

    // dot product of the current samples with one lane's taps
    function automatic conv_pkg::acc_t dot_ref(input int lane);
        conv_pkg::acc_t sum;
        sum = '0;
        for (int t = 0; t < `CONV_TAPS; t++) begin
            sum = sum + conv_pkg::acc_t'(samples[t]) * conv_pkg::acc_t'(coefs[lane][t]);
        end
        return sum;
    endfunction

    always @(negedge clk) begin
        while (exp_q.size() > 0) begin
            check_acc(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
        end
    end

    // one setup and one access phase, starts and ends just after an edge
    task automatic bus_transfer(input logic write, input conv_pkg::apb_addr_t addr,
                                input conv_pkg::apb_data_t wdata,
                                output conv_pkg::apb_data_t rdata, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DLY apb_req.penable = 1'b1;
        @(negedge clk);     // prdata settled mid access phase
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_flag("pready", 1'b1, apb_rsp.pready);
        @(posedge clk);
        #DRIVE_DLY;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic write_reg(input conv_pkg::apb_addr_t addr, input conv_pkg::apb_data_t data,
                             output logic err);
        conv_pkg::apb_data_t unused;
        bus_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic read_reg(input conv_pkg::apb_addr_t addr, output conv_pkg::apb_data_t data,
                            output logic err);
        bus_transfer(1'b0, addr, '0, data, err);
    endtask

    function automatic conv_pkg::apb_addr_t coef_addr(input int lane, input int tap);
        return `CONV_REG_COEF_BASE + lane * `CONV_COEF_LANE_STRIDE + tap * `CONV_COEF_TAP_STRIDE;
    endfunction

    task automatic load_coefs();
        logic err;
        for (int l = 0; l < `CONV_LANES; l++) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                write_reg(coef_addr(l, t), {16'h0, coefs[l][t]}, err);
                check_flag("pslverr on coef write", 1'b0, err);
            end
        end
    endtask

    task automatic randomize_samples();
        for (int t = 0; t < `CONV_TAPS; t++) begin
            samples[t] = conv_pkg::sample_t'($urandom());
        end
    endtask

    // back to back DATA writes, no idle cycle in between
    task automatic feed_samples(input int first_tap, input int count);
        logic err;
        for (int t = first_tap; t < first_tap + count; t++) begin
            write_reg(`CONV_REG_DATA, {16'h0, samples[t]}, err);
            check_flag("pslverr on data write", 1'b0, err);
        end
        if (first_tap + count == `CONV_TAPS) blocks++;
    endtask

    task automatic wait_block();
        conv_pkg::apb_data_t status;
        logic                err;
        int                  polls;
        polls = 0;
        status = '0;
        while (!(status[0] && status[15:8] == blocks[7:0]) && polls < POLL_MAX) begin
            read_reg(`CONV_REG_STATUS, status, err);
            polls++;
        end
        if (!(status[0] && status[15:8] == blocks[7:0])) begin
            $display("error at %0t: block %0d never raised done", $time, blocks);
            errs++;
        end
    endtask

    task automatic check_results();
        conv_pkg::apb_data_t lo;
        conv_pkg::apb_data_t hi;
        conv_pkg::acc_t      exp;
        logic                err;
        for (int l = 0; l < `CONV_LANES; l++) begin
            read_reg(`CONV_REG_RESULT_BASE + l * `CONV_RESULT_LANE_STRIDE, lo, err);
            read_reg(`CONV_REG_RESULT_BASE + l * `CONV_RESULT_LANE_STRIDE + 4, hi, err);
            exp = dot_ref(l);
            exp_q.push_back(exp);
            act_q.push_back(conv_pkg::acc_t'({hi[3:0], lo}));
            name_q.push_back($sformatf("result[%0d]", l));
            check_word($sformatf("result[%0d] high word", l), {{28{exp[35]}}, exp[35:32]}, hi);
        end
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) @(posedge clk);
        if (errs == test_start_errs) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs - test_start_errs);
        end
        test_start_errs = errs;
    endtask

    initial begin
        conv_pkg::apb_data_t d;
        logic                e;
        void'($urandom(32'hd4d96560));
        rst = 1'b1;
        apb_req = '0;
        blocks = 0;
        errs = 0;
        test_start_errs = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY rst = 1'b0;

        read_reg(`CONV_REG_STATUS, d, e);
        check_word("status", 32'h0, d);
        for (int l = 0; l < `CONV_LANES; l++) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                read_reg(coef_addr(l, t), d, e);
                check_word($sformatf("coef[%0d][%0d]", l, t), 32'h0, d);
            end
            for (int w = 0; w < 2; w++) begin
                read_reg(`CONV_REG_RESULT_BASE + l * `CONV_RESULT_LANE_STRIDE + 4 * w, d, e);
                check_word($sformatf("result[%0d] word %0d", l, w), 32'h0, d);
            end
        end
        finish_test("reset_values");

        for (int l = 0; l < `CONV_LANES; l++) begin
            for (int t = 0; t < `CONV_TAPS; t++) coefs[l][t] = conv_pkg::coef_t'($urandom());
        end
        load_coefs();
        write_reg(`CONV_REG_RESULT_BASE, 32'hdead_beef, e);
        check_flag("pslverr on result write", 1'b1, e);
        write_reg(12'h180, 32'h0000_1234, e);      // just past the coef area
        check_flag("pslverr on unmapped write", 1'b1, e);
        read_reg(`CONV_REG_RESULT_BASE, d, e);
        check_word("result[0] word 0", 32'h0, d);
        read_reg(`CONV_REG_STATUS, d, e);
        check_word("status", 32'h0, d);
        for (int l = 0; l < `CONV_LANES; l++) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                read_reg(coef_addr(l, t), d, e);
                check_word($sformatf("coef[%0d][%0d]", l, t), {16'h0, coefs[l][t]}, d);
            end
        end
        finish_test("coef_access");

        for (int l = 0; l < `CONV_LANES; l++) begin
            for (int t = 0; t < `CONV_TAPS; t++) coefs[l][t] = conv_pkg::coef_t'($urandom());
        end
        for (int t = 0; t < `CONV_TAPS; t++) coefs[1][t] = 16'sh8000;  // most negative
        coefs[0][0] = 16'sh8000;
        coefs[2][7] = 16'sh7fff;
        load_coefs();
        randomize_samples();
        samples[0] = 16'sh8000;
        samples[7] = 16'sh8000;
        feed_samples(0, `CONV_TAPS);
        wait_block();
        check_results();
        finish_test("first_block");

        for (int t = 0; t < `CONV_TAPS; t++) samples[t] = 16'sh8000;  // lane 1 hits 2**33
        feed_samples(0, `CONV_TAPS);
        wait_block();
        check_results();
        read_reg(`CONV_REG_STATUS, d, e);
        check_word("block_cnt", 32'd2, {24'h0, d[15:8]});
        finish_test("second_block");

        write_reg(`CONV_REG_STATUS, 32'h1, e);
        read_reg(`CONV_REG_STATUS, d, e);
        check_flag("done", 1'b0, d[0]);
        randomize_samples();
        feed_samples(0, 4);
        read_reg(`CONV_REG_STATUS, d, e);
        check_flag("busy", 1'b1, d[1]);
        feed_samples(4, 4);
        read_reg(`CONV_REG_STATUS, d, e);
        check_flag("busy", 1'b0, d[1]);
        wait_block();
        check_results();
        finish_test("done_and_busy");

        randomize_samples();
        feed_samples(0, `CONV_TAPS);
        randomize_samples();    // second block follows without a gap
        feed_samples(0, `CONV_TAPS);
        wait_block();
        check_results();
        read_reg(`CONV_REG_STATUS, d, e);
        check_word("block_cnt", 32'd5, {24'h0, d[15:8]});
        finish_test("back_to_back");

        $display("tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, errs);
        if (errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
hw/conv_pkg.sv
hw/conv_apb_regs.sv
hw/conv_feeder.sv
hw/mac_lane.sv
hw/conv_collector.sv
hw/conv_top.sv
tests/conv_tb.sv
